// ==== Bender.yml ====
package:
  name: mcycle_cpu

export_include_dirs:
  - common

sources:
  - files:
      - common/cpu_pkg.sv
      - hdl/cpu_fsm.sv
      - hdl/pc_unit.sv
      - decode/inst_decoder.sv
      - hdl/regfile.sv
      - hdl/alu.sv
      - hdl/exec_unit.sv
      - hdl/mcycle_cpu_top.sv
  - target: test
    files:
      - testbench/cpu_chk.sv
      - testbench/tb_mcycle_cpu.sv

// ==== common/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data and address width.
`define CPU_XLEN 32

// Architectural registers.
`define CPU_NREG 32

// First fetch address after reset.
`define CPU_RESET_PC 32'h1c00_0000

`endif

// ==== common/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // ****************************************
    // Sequencer states.
    // ****************************************
    typedef enum logic [2:0] {
        st_if,
        st_id,
        st_exe,
        st_mem,
        st_wb
    } cpu_state_e;

    // ****************************************
    // ALU operations.
    // ****************************************
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    // Second operand immediate format.
    typedef enum logic [1:0] {
        imm_ui5,
        imm_si12,
        imm_si20,
        imm_four    // Link offset for bl and jirl.
    } imm_sel_e;

endpackage

`default_nettype wire

// ==== decode/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module inst_decoder (
    input  wire [31:0]                 inst,
    output logic                       is_branch_only,
    output logic                       is_mem,
    output logic                       is_load,
    output logic                       is_store,
    output logic                       is_beq,
    output logic                       is_bne,
    output logic                       is_jirl,
    output logic                       is_bl,
    output cpu_pkg::alu_op_e           alu_op,
    output cpu_pkg::imm_sel_e          imm_sel,
    output logic                       src1_is_pc,
    output logic                       src2_is_imm,
    output logic                       gr_we,
    output logic [$clog2(`CPU_NREG)-1:0] rj,
    output logic [$clog2(`CPU_NREG)-1:0] rkd,
    output logic [$clog2(`CPU_NREG)-1:0] dest,
    output logic [`CPU_XLEN-1:0]       imm,
    output logic [`CPU_XLEN-1:0]       br_offs
);

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [4:0]  rd;
    logic [4:0]  rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic        is_3r;
    logic        is_sh;
    logic        inst_add_w;
    logic        inst_sub_w;
    logic        inst_slt;
    logic        inst_sltu;
    logic        inst_nor;
    logic        inst_and;
    logic        inst_or;
    logic        inst_xor;
    logic        inst_slli_w;
    logic        inst_srli_w;
    logic        inst_srai_w;
    logic        inst_addi_w;
    logic        inst_lu12i_w;
    logic        inst_b;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rk       = inst[14:10];
    assign rj       = inst[9:5];
    assign i12      = inst[21:10];
    assign i20      = inst[24:5];
    assign i16      = inst[25:10];
    assign i26      = {inst[9:0], inst[25:10]};

    // ****************************************
    // Opcode match.
    // ****************************************
    assign is_3r = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign is_sh = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    assign inst_add_w   = is_3r && (op_19_15 == 5'h00);
    assign inst_sub_w   = is_3r && (op_19_15 == 5'h02);
    assign inst_slt     = is_3r && (op_19_15 == 5'h04);
    assign inst_sltu    = is_3r && (op_19_15 == 5'h05);
    assign inst_nor     = is_3r && (op_19_15 == 5'h08);
    assign inst_and     = is_3r && (op_19_15 == 5'h09);
    assign inst_or      = is_3r && (op_19_15 == 5'h0a);
    assign inst_xor     = is_3r && (op_19_15 == 5'h0b);
    assign inst_slli_w  = is_sh && (op_19_15 == 5'h01);
    assign inst_srli_w  = is_sh && (op_19_15 == 5'h09);
    assign inst_srai_w  = is_sh && (op_19_15 == 5'h11);
    assign inst_addi_w  = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign is_load      = (op_31_26 == 6'h0a) && (op_25_22 == 4'h2);
    assign is_store     = (op_31_26 == 6'h0a) && (op_25_22 == 4'h6);
    assign is_jirl      = (op_31_26 == 6'h13);
    assign inst_b       = (op_31_26 == 6'h14);
    assign is_bl        = (op_31_26 == 6'h15);
    assign is_beq       = (op_31_26 == 6'h16);
    assign is_bne       = (op_31_26 == 6'h17);
    assign inst_lu12i_w = (op_31_26 == 6'h05) && !inst[25];

    assign is_branch_only = inst_b | is_beq | is_bne;
    assign is_mem         = is_load | is_store;

    // Address, addi and link all fall through to add.
    assign alu_op = inst_sub_w   ? cpu_pkg::alu_sub  :
                    inst_slt     ? cpu_pkg::alu_slt  :
                    inst_sltu    ? cpu_pkg::alu_sltu :
                    inst_and     ? cpu_pkg::alu_and  :
                    inst_nor     ? cpu_pkg::alu_nor  :
                    inst_or      ? cpu_pkg::alu_or   :
                    inst_xor     ? cpu_pkg::alu_xor  :
                    inst_slli_w  ? cpu_pkg::alu_sll  :
                    inst_srli_w  ? cpu_pkg::alu_srl  :
                    inst_srai_w  ? cpu_pkg::alu_sra  :
                    inst_lu12i_w ? cpu_pkg::alu_lui  :
                                   cpu_pkg::alu_add;

    assign imm_sel = (inst_slli_w | inst_srli_w | inst_srai_w) ? cpu_pkg::imm_ui5  :
                     inst_lu12i_w                              ? cpu_pkg::imm_si20 :
                     (is_jirl | is_bl)                         ? cpu_pkg::imm_four :
                                                                 cpu_pkg::imm_si12;

    assign src1_is_pc  = is_jirl | is_bl;
    assign src2_is_imm = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w
                       | is_load | is_store | inst_lu12i_w | is_jirl | is_bl;
    assign gr_we = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                 | inst_or | inst_xor | inst_slli_w | inst_srli_w | inst_srai_w
                 | inst_addi_w | inst_lu12i_w | is_load | is_jirl | is_bl;

    assign rkd  = (is_beq | is_bne | is_store) ? rd : rk;
    assign dest = is_bl ? 5'd1 : rd; // bl links through r1.

    // ****************************************
    // Immediates.
    // ****************************************
    always_comb begin
        case (imm_sel)
            cpu_pkg::imm_ui5:  imm = {27'b0, rk};
            cpu_pkg::imm_si20: imm = {i20, 12'b0};
            default:           imm = {{20{i12[11]}}, i12};
        endcase
    end

    assign br_offs = (inst_b | is_bl) ? {{4{i26[25]}}, i26, 2'b0}
                                      : {{14{i16[15]}}, i16, 2'b0};

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module alu (
    input  wire cpu_pkg::alu_op_e    op,
    input  wire [`CPU_XLEN-1:0]      src1,
    input  wire [`CPU_XLEN-1:0]      src2,
    output logic [`CPU_XLEN-1:0]     result
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = src2[4:0];
    assign lt_s  = $signed(src1) < $signed(src2);
    assign lt_u  = src1 < src2;

    always_comb begin
        case (op)
            cpu_pkg::alu_add:  result = src1 + src2;
            cpu_pkg::alu_sub:  result = src1 - src2;
            cpu_pkg::alu_slt:  result = {{(`CPU_XLEN-1){1'b0}}, lt_s};
            cpu_pkg::alu_sltu: result = {{(`CPU_XLEN-1){1'b0}}, lt_u};
            cpu_pkg::alu_and:  result = src1 & src2;
            cpu_pkg::alu_nor:  result = ~(src1 | src2);
            cpu_pkg::alu_or:   result = src1 | src2;
            cpu_pkg::alu_xor:  result = src1 ^ src2;
            cpu_pkg::alu_sll:  result = src1 << shamt;
            cpu_pkg::alu_srl:  result = src1 >> shamt;
            cpu_pkg::alu_sra:  result = $signed(src1) >>> shamt;
            cpu_pkg::alu_lui:  result = src2;   // Immediate already shifted up.
            default:           result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_fsm (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 is_branch_only,
    input  wire                 is_mem,
    input  wire                 is_load,
    output cpu_pkg::cpu_state_e state
);

    cpu_pkg::cpu_state_e next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpu_pkg::st_if;
        end else begin
            state <= next_state;
        end
    end

    // ID uses live decode, later states the latched class.
    always_comb begin
        case (state)
            cpu_pkg::st_if: begin
                next_state = cpu_pkg::st_id;
            end
            cpu_pkg::st_id: begin
                next_state = is_branch_only ? cpu_pkg::st_if : cpu_pkg::st_exe;
            end
            cpu_pkg::st_exe: begin
                next_state = is_mem ? cpu_pkg::st_mem : cpu_pkg::st_wb;
            end
            cpu_pkg::st_mem: begin
                next_state = is_load ? cpu_pkg::st_wb : cpu_pkg::st_if; // Store ends here.
            end
            default: begin
                next_state = cpu_pkg::st_if;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module exec_unit (
    input  wire                          clk,
    input  wire                          reset,
    input  wire cpu_pkg::cpu_state_e     state,
    input  wire [`CPU_XLEN-1:0]          pc,
    input  wire                          is_branch_only,
    input  wire                          is_mem,
    input  wire                          is_load,
    input  wire                          is_store,
    input  wire                          is_beq,
    input  wire                          is_bne,
    input  wire                          is_jirl,
    input  wire                          is_bl,
    input  wire cpu_pkg::alu_op_e        alu_op,
    input  wire cpu_pkg::imm_sel_e       imm_sel,
    input  wire                          src1_is_pc,
    input  wire                          src2_is_imm,
    input  wire                          gr_we,
    input  wire [$clog2(`CPU_NREG)-1:0]  dest,
    input  wire [`CPU_XLEN-1:0]          imm,
    input  wire [`CPU_XLEN-1:0]          br_offs,
    input  wire [`CPU_XLEN-1:0]          rdata1,
    input  wire [`CPU_XLEN-1:0]          rdata2,
    input  wire [`CPU_XLEN-1:0]          data_sram_rdata,
    output logic                         branch_taken,
    output logic [`CPU_XLEN-1:0]         branch_target,
    output logic                         data_sram_we,
    output logic [`CPU_XLEN-1:0]         data_sram_addr,
    output logic [`CPU_XLEN-1:0]         data_sram_wdata,
    output logic                         rf_we,
    output logic [$clog2(`CPU_NREG)-1:0] wb_dest,
    output logic [`CPU_XLEN-1:0]         wb_data,
    output logic [`CPU_XLEN-1:0]         wb_pc,
    output logic                         ex_is_mem,
    output logic                         ex_is_load
);

    logic [`CPU_XLEN-1:0] src1_q;
    logic [`CPU_XLEN-1:0] src2_q;
    logic [`CPU_XLEN-1:0] store_data_q;
    logic [`CPU_XLEN-1:0] src2_imm;
    logic [`CPU_XLEN-1:0] alu_result;
    cpu_pkg::alu_op_e     alu_op_q;
    logic                 is_store_q;
    logic                 gr_we_q;
    logic                 rj_eq_rkd;
    logic                 result_en;

    // ****************************************
    // Branch resolution in ID.
    // ****************************************
    assign rj_eq_rkd     = (rdata1 == rdata2);
    assign branch_taken  = (is_beq & rj_eq_rkd) | (is_bne & ~rj_eq_rkd)
                         | (is_branch_only & ~is_beq & ~is_bne) | is_bl | is_jirl;
    assign branch_target = (is_jirl ? rdata1 : pc) + br_offs;

    assign src2_imm = (imm_sel == cpu_pkg::imm_four) ? `CPU_XLEN'(4) : imm;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_is_mem  <= 1'b0;
            ex_is_load <= 1'b0;
            is_store_q <= 1'b0;
            gr_we_q    <= 1'b0;
        end else if (state == cpu_pkg::st_id) begin
            ex_is_mem  <= is_mem;
            ex_is_load <= is_load;
            is_store_q <= is_store;
            gr_we_q    <= gr_we;
        end
    end

    // Operands and write-back tags.
    always_ff @(posedge clk) begin
        if (state == cpu_pkg::st_id) begin
            src1_q       <= src1_is_pc ? pc : rdata1;
            src2_q       <= src2_is_imm ? src2_imm : rdata2;
            store_data_q <= rdata2;    // rd value for st.w.
            alu_op_q     <= alu_op;
            wb_dest      <= dest;
            wb_pc        <= pc;
        end
    end

    alu u_alu (
        .op     (alu_op_q),
        .src1   (src1_q),
        .src2   (src2_q),
        .result (alu_result)
    );

    // ****************************************
    // Memory and result.
    // ****************************************
    assign data_sram_we    = (state == cpu_pkg::st_exe) & is_store_q;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = store_data_q;

    assign result_en = ex_is_load ? (state == cpu_pkg::st_mem) : (state == cpu_pkg::st_exe);

    always_ff @(posedge clk) begin
        if (result_en) begin
            wb_data <= ex_is_load ? data_sram_rdata : alu_result;
        end
    end

    assign rf_we = (state == cpu_pkg::st_wb) & gr_we_q;

endmodule

`default_nettype wire

// ==== hdl/mcycle_cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module mcycle_cpu_top (
    input  wire                          clk,
    input  wire                          reset,
    output logic [`CPU_XLEN-1:0]         inst_sram_addr,
    input  wire [`CPU_XLEN-1:0]          inst_sram_rdata,
    output logic                         data_sram_we,
    output logic [`CPU_XLEN-1:0]         data_sram_addr,
    output logic [`CPU_XLEN-1:0]         data_sram_wdata,
    input  wire [`CPU_XLEN-1:0]          data_sram_rdata,
    output logic [`CPU_XLEN-1:0]         debug_wb_pc,
    output logic                         debug_wb_rf_we,
    output logic [$clog2(`CPU_NREG)-1:0] debug_wb_rf_wnum,
    output logic [`CPU_XLEN-1:0]         debug_wb_rf_wdata
);

    localparam int RW = $clog2(`CPU_NREG);

    cpu_pkg::cpu_state_e  state;
    cpu_pkg::alu_op_e     alu_op;
    cpu_pkg::imm_sel_e    imm_sel;
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] branch_target;
    logic [`CPU_XLEN-1:0] imm;
    logic [`CPU_XLEN-1:0] br_offs;
    logic [`CPU_XLEN-1:0] rdata1;
    logic [`CPU_XLEN-1:0] rdata2;
    logic [RW-1:0]        rj;
    logic [RW-1:0]        rkd;
    logic [RW-1:0]        dest;
    logic                 branch_taken;
    logic                 is_branch_only;
    logic                 is_mem;
    logic                 is_load;
    logic                 is_store;
    logic                 is_beq;
    logic                 is_bne;
    logic                 is_jirl;
    logic                 is_bl;
    logic                 src1_is_pc;
    logic                 src2_is_imm;
    logic                 gr_we;
    logic                 ex_is_mem;
    logic                 ex_is_load;

    assign inst_sram_addr = pc;

    cpu_fsm u_fsm (
        .clk            (clk),
        .reset          (reset),
        .is_branch_only (is_branch_only),
        .is_mem         (ex_is_mem),
        .is_load        (ex_is_load),
        .state          (state)
    );

    pc_unit u_pc (
        .clk           (clk),
        .reset         (reset),
        .state         (state),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (pc)
    );

    inst_decoder u_dec (
        .inst           (inst_sram_rdata),
        .is_branch_only (is_branch_only),
        .is_mem         (is_mem),
        .is_load        (is_load),
        .is_store       (is_store),
        .is_beq         (is_beq),
        .is_bne         (is_bne),
        .is_jirl        (is_jirl),
        .is_bl          (is_bl),
        .alu_op         (alu_op),
        .imm_sel        (imm_sel),
        .src1_is_pc     (src1_is_pc),
        .src2_is_imm    (src2_is_imm),
        .gr_we          (gr_we),
        .rj             (rj),
        .rkd            (rkd),
        .dest           (dest),
        .imm            (imm),
        .br_offs        (br_offs)
    );

    regfile u_rf (
        .clk    (clk),
        .raddr1 (rj),
        .rdata1 (rdata1),
        .raddr2 (rkd),
        .rdata2 (rdata2),
        .we     (debug_wb_rf_we),
        .waddr  (debug_wb_rf_wnum),
        .wdata  (debug_wb_rf_wdata)
    );

    // Write-back side doubles as the trace port.
    exec_unit u_exec (
        .clk             (clk),
        .reset           (reset),
        .state           (state),
        .pc              (pc),
        .is_branch_only  (is_branch_only),
        .is_mem          (is_mem),
        .is_load         (is_load),
        .is_store        (is_store),
        .is_beq          (is_beq),
        .is_bne          (is_bne),
        .is_jirl         (is_jirl),
        .is_bl           (is_bl),
        .alu_op          (alu_op),
        .imm_sel         (imm_sel),
        .src1_is_pc      (src1_is_pc),
        .src2_is_imm     (src2_is_imm),
        .gr_we           (gr_we),
        .dest            (dest),
        .imm             (imm),
        .br_offs         (br_offs),
        .rdata1          (rdata1),
        .rdata2          (rdata2),
        .data_sram_rdata (data_sram_rdata),
        .branch_taken    (branch_taken),
        .branch_target   (branch_target),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .rf_we           (debug_wb_rf_we),
        .wb_dest         (debug_wb_rf_wnum),
        .wb_data         (debug_wb_rf_wdata),
        .wb_pc           (debug_wb_pc),
        .ex_is_mem       (ex_is_mem),
        .ex_is_load      (ex_is_load)
    );

endmodule

`default_nettype wire

// ==== hdl/pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module pc_unit (
    input  wire                      clk,
    input  wire                      reset,
    input  wire cpu_pkg::cpu_state_e state,
    input  wire                      branch_taken,
    input  wire [`CPU_XLEN-1:0]      branch_target,
    output logic [`CPU_XLEN-1:0]     pc
);

    logic [`CPU_XLEN-1:0] seq_pc;

    assign seq_pc = pc + `CPU_XLEN'(4);

    // Next fetch address is settled at the end of ID.
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `CPU_RESET_PC;
        end else if (state == cpu_pkg::st_id) begin
            pc <= branch_taken ? branch_target : seq_pc;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module regfile (
    input  wire                          clk,
    input  wire [$clog2(`CPU_NREG)-1:0]  raddr1,
    output logic [`CPU_XLEN-1:0]         rdata1,
    input  wire [$clog2(`CPU_NREG)-1:0]  raddr2,
    output logic [`CPU_XLEN-1:0]         rdata2,
    input  wire                          we,
    input  wire [$clog2(`CPU_NREG)-1:0]  waddr,
    input  wire [`CPU_XLEN-1:0]          wdata
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREG];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads as zero whatever was written.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/cpu_pkg.sv
hdl/cpu_fsm.sv
hdl/pc_unit.sv
decode/inst_decoder.sv
hdl/regfile.sv
hdl/alu.sv
hdl/exec_unit.sv
hdl/mcycle_cpu_top.sv
testbench/cpu_chk.sv
testbench/tb_mcycle_cpu.sv

// ==== testbench/cpu_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_chk (
    input wire clk,
    input wire reset,
    input wire debug_wb_rf_we,
    input wire data_sram_we
);

    int fail_count = 0;

    // Strobes come out of reset low.
    reset_quiet: assert property (@(posedge clk) reset |=> !debug_wb_rf_we && !data_sram_we)
        else begin
            $error("write strobes not low in the cycle after reset");
            fail_count++;
        end

    no_overlap: assert property (@(posedge clk) disable iff (reset)
        !(debug_wb_rf_we && data_sram_we))
        else begin
            $error("register write and data SRAM write high together");
            fail_count++;
        end

    wb_single: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we |=> !debug_wb_rf_we)
        else begin
            $error("write-back strobe high in two consecutive cycles");
            fail_count++;
        end

endmodule

bind mcycle_cpu_top cpu_chk chk (
    .clk            (clk),
    .reset          (reset),
    .debug_wb_rf_we (debug_wb_rf_we),
    .data_sram_we   (data_sram_we)
);

`default_nettype wire

// ==== testbench/tb_mcycle_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module tb_mcycle_cpu;

    localparam int clk_period = 8;

    localparam logic [31:0] op_add   = 32'h0010_0000;
    localparam logic [31:0] op_sub   = 32'h0011_0000;
    localparam logic [31:0] op_slt   = 32'h0012_0000;
    localparam logic [31:0] op_sltu  = 32'h0012_8000;
    localparam logic [31:0] op_nor   = 32'h0014_0000;
    localparam logic [31:0] op_and   = 32'h0014_8000;
    localparam logic [31:0] op_or    = 32'h0015_0000;
    localparam logic [31:0] op_xor   = 32'h0015_8000;
    localparam logic [31:0] op_slli  = 32'h0040_8000;
    localparam logic [31:0] op_srli  = 32'h0044_8000;
    localparam logic [31:0] op_srai  = 32'h0048_8000;
    localparam logic [31:0] op_addi  = 32'h0280_0000;
    localparam logic [31:0] op_lu12i = 32'h1400_0000;
    localparam logic [31:0] op_ld    = 32'h2880_0000;
    localparam logic [31:0] op_st    = 32'h2980_0000;
    localparam logic [31:0] op_jirl  = 32'h4c00_0000;
    localparam logic [31:0] op_b     = 32'h5000_0000;
    localparam logic [31:0] op_bl    = 32'h5400_0000;
    localparam logic [31:0] op_beq   = 32'h5800_0000;
    localparam logic [31:0] op_bne   = 32'h5c00_0000;

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] rnd [4];
    logic [31:0] r [32];       // Architectural register model.
    logic [31:0] exp_pc [64];
    logic [4:0]  exp_reg [64];
    logic [31:0] exp_val [64];
    int          exp_gap [64];
    string       exp_name [64];
    int          n_exp = 0;
    int          n_seen = 0;
    int          n_run = 0;
    int          pend = 0;
    int          cyc = 0;
    int          last_cyc = 0;
    int          errors = 0;
    bit          built = 0;
    integer      seed;

    mcycle_cpu_top dut (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #(clk_period / 2) clk = ~clk;

    // ****************************************
    // SRAM models with one-cycle read latency.
    // ****************************************
    always @(posedge clk) begin
        inst_sram_rdata <= imem[inst_sram_addr[9:2]];
    end

    always @(posedge clk) begin
        if (data_sram_we) begin
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        end
        data_sram_rdata <= dmem[data_sram_addr[9:2]];
    end

    // ****************************************
    // Instruction encoding.
    // ****************************************
    function automatic logic [31:0] three_reg(input logic [31:0] op, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [4:0] rk);
        return op | {17'b0, rk, rj, rd};
    endfunction

    function automatic logic [31:0] imm12_op(input logic [31:0] op, input logic [4:0] rd,
                                             input logic [4:0] rj, input logic [11:0] imm);
        return op | {10'b0, imm, rj, rd};
    endfunction

    function automatic logic [31:0] imm20_op(input logic [31:0] op, input logic [4:0] rd,
                                             input logic [19:0] imm);
        return op | {7'b0, imm, rd};
    endfunction

    function automatic logic [31:0] offs16_op(input logic [31:0] op, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [15:0] offs);
        return op | {6'b0, offs, rj, rd};
    endfunction

    function automatic logic [31:0] offs26_op(input logic [31:0] op, input logic [25:0] offs);
        return op | {6'b0, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [31:0] addr_of(input int idx);
        return `CPU_RESET_PC + 32'(4 * idx);
    endfunction

    // Places an instruction that writes a register, in execution order.
    task automatic run(input int idx, input logic [31:0] word, input int cycles,
                       input logic [4:0] rd, input logic [31:0] value, input string name);
        imem[idx]       = word;
        exp_pc[n_exp]   = addr_of(idx);
        exp_reg[n_exp]  = rd;
        exp_val[n_exp]  = value;
        exp_gap[n_exp]  = pend + cycles;   // Includes preceding branches and stores.
        exp_name[n_exp] = name;
        n_exp++;
        n_run++;
        pend = 0;
        if (rd != 5'd0) begin
            r[rd] = value;
        end
    endtask

    task automatic run_quiet(input int idx, input logic [31:0] word, input int cycles);
        imem[idx] = word;
        pend += cycles;
        n_run++;
    endtask

    task automatic build_program();
        run(0, imm20_op(op_lu12i, 4, 20'h80001), 4, 4, {20'h80001, 12'h000}, "lu12i.w");
        run(1, imm12_op(op_addi, 5, 0, 12'hffd), 4, 5, r[0] - 32'd3, "addi.w neg");
        run(2, imm12_op(op_addi, 6, 0, 12'h123), 4, 6, r[0] + 32'h123, "addi.w pos");
        run(3, three_reg(op_add, 7, 4, 6), 4, 7, r[4] + r[6], "add.w");
        run(4, three_reg(op_sub, 8, 6, 5), 4, 8, r[6] - r[5], "sub.w");
        run(5, three_reg(op_slt, 9, 5, 6), 4, 9, $signed(r[5]) < $signed(r[6]), "slt mixed");
        run(6, three_reg(op_sltu, 10, 5, 6), 4, 10, r[5] < r[6], "sltu mixed");
        run(7, three_reg(op_slt, 11, 4, 5), 4, 11, $signed(r[4]) < $signed(r[5]), "slt neg");
        run(8, three_reg(op_sltu, 12, 6, 4), 4, 12, r[6] < r[4], "sltu high");
        run(9, three_reg(op_and, 13, 4, 5), 4, 13, r[4] & r[5], "and");
        run(10, three_reg(op_or, 14, 4, 6), 4, 14, r[4] | r[6], "or");
        run(11, three_reg(op_nor, 15, 5, 6), 4, 15, ~(r[5] | r[6]), "nor");
        run(12, three_reg(op_xor, 16, 4, 5), 4, 16, r[4] ^ r[5], "xor");
        run(13, three_reg(op_slli, 17, 5, 4), 4, 17, r[5] << 4, "slli.w");
        run(14, three_reg(op_srli, 18, 4, 8), 4, 18, r[4] >> 8, "srli.w");
        run(15, three_reg(op_srai, 19, 4, 8), 4, 19, $signed(r[4]) >>> 8, "srai.w");
        run(16, imm12_op(op_addi, 20, 0, 12'h040), 4, 20, 32'h40, "addi.w base");
        run_quiet(17, imm12_op(op_st, 7, 20, 12'h000), 4);
        run(18, imm12_op(op_ld, 21, 20, 12'h000), 5, 21, r[7], "ld.w after st.w");
        for (int i = 0; i < 4; i++) begin
            run(19 + i, imm12_op(op_ld, 22 + i, 0, 12'(4 * i)), 5, 22 + i, rnd[i], "ld.w seeded");
        end
        run_quiet(23, offs16_op(op_beq, 6, 6, 16'd2), 2);     // Taken.
        imem[24] = imm12_op(op_addi, 26, 0, 12'h001);         // Skipped.
        run_quiet(25, offs16_op(op_beq, 6, 5, 16'd2), 2);     // Not taken.
        run(26, imm12_op(op_addi, 26, 0, 12'h007), 4, 26, 32'h7, "beq paths");
        run_quiet(27, offs16_op(op_bne, 6, 5, 16'd2), 2);     // Taken.
        imem[28] = imm12_op(op_addi, 27, 0, 12'h001);
        run_quiet(29, offs16_op(op_bne, 6, 6, 16'd2), 2);     // Not taken.
        run_quiet(30, offs26_op(op_b, 26'd2), 2);
        imem[31] = imm12_op(op_addi, 27, 0, 12'h002);
        run(32, offs26_op(op_bl, 26'd3), 4, 1, addr_of(33), "bl link");
        run(35, imm12_op(op_addi, 0, 0, 12'h005), 4, 0, 32'h5, "addi.w to r0");
        run(36, three_reg(op_add, 29, 0, 6), 4, 29, r[0] + r[6], "r0 reads zero");
        run(37, offs16_op(op_jirl, 30, 1, 16'd0), 4, 30, addr_of(38), "jirl link");
        run(33, imm12_op(op_addi, 28, 0, 12'h009), 4, 28, 32'h9, "jirl return");
        run_quiet(34, offs26_op(op_b, 26'd4), 2);
        run_quiet(38, offs26_op(op_b, 26'd0), 2);             // Parks the core.
    endtask

    // ****************************************
    // Trace checking.
    // ****************************************
    task automatic mismatch(input string name, input string field,
                            input logic [31:0] expected, input logic [31:0] actual);
        errors++;
        $display("ERROR %s: %s expected %0h actual %0h", name, field, expected, actual);
    endtask

    task automatic check_write();
        if (n_seen >= n_exp) begin
            errors++;
            $display("Unexpected register write to r%0d at pc %h after the last trace entry",
                     debug_wb_rf_wnum, debug_wb_pc);
        end else begin
            assert (debug_wb_pc == exp_pc[n_seen])
                else mismatch(exp_name[n_seen], "pc", exp_pc[n_seen], debug_wb_pc);
            assert (debug_wb_rf_wnum == exp_reg[n_seen])
                else mismatch(exp_name[n_seen], "wnum", exp_reg[n_seen], debug_wb_rf_wnum);
            assert (debug_wb_rf_wdata == exp_val[n_seen])
                else mismatch(exp_name[n_seen], "wdata", exp_val[n_seen], debug_wb_rf_wdata);
            assert (cyc - last_cyc == exp_gap[n_seen])
                else mismatch(exp_name[n_seen], "cycles", exp_gap[n_seen], cyc - last_cyc);
            last_cyc = cyc;
            n_seen++;
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            cyc = cyc + 1;
            if (debug_wb_rf_we) begin
                check_write();
            end
        end
    end

    initial begin
        wait (built);
        #((n_run * 5 + 40) * clk_period);
        $display("Timeout: the program did not retire all expected writes in time");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        seed            = 32'h2422_efb5;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'hd0d0_0000 + i;
        end
        for (int i = 0; i < 4; i++) begin
            rnd[i]  = $random(seed);
            dmem[i] = rnd[i];
        end
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        build_program();
        built = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        wait (n_seen == n_exp);
        repeat (20) @(posedge clk);     // Room for stray writes.
        $display("Errors: %0d trace mismatches, %0d assertion failures",
                 errors, dut.chk.fail_count);
        if (errors == 0 && dut.chk.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
